/* alu_pkg.sv */
// Shared ALU types and widths; opcode encoding is internal and carries no Z80 opcode values
package alu_pkg;

  // Word and byte datapath widths
  localparam int ALU_W  = 16;
  localparam int ALU_BW = 8;

  // Adder is built from nibble slices
  localparam int ALU_NW  = 4;
  localparam int ALU_NIB = ALU_W / ALU_NW;

  // Opcode field width
  localparam int ALU_OPW = 4;

  // Decimal adjust constants
  localparam logic [ALU_NW-1:0] DAA_LO_MAX  = 4'h9;
  localparam logic [ALU_BW-1:0] DAA_HI_MAX  = 8'h99;
  localparam logic [ALU_BW-1:0] DAA_LO_CORR = 8'h06;
  localparam logic [ALU_BW-1:0] DAA_HI_CORR = 8'h60;

  // Operation select
  typedef enum logic [ALU_OPW-1:0] {
    // Word arithmetic
    AOP_ADD,
    AOP_ADC,
    AOP_SUB,
    AOP_SBC,
    // Word plus sign-extended byte
    AOP_ADS,
    // Byte arithmetic
    AOP_BADD,
    AOP_BADC,
    AOP_BSUB,
    AOP_BSBC,
    // Byte logic
    AOP_AND,
    AOP_OR,
    AOP_XOR,
    // Decimal adjust of the low byte of a
    AOP_DAA
  } alu_op_t;

  // Processor flag set, Z80 naming
  typedef struct packed {
    // Sign
    logic s;
    // Zero
    logic z;
    // Half carry, bit 3 or bit 11
    logic h;
    // Parity or overflow
    logic pv;
    // Last op was a subtract
    logic n;
    // Carry or borrow
    logic c;
  } alu_flags_t;

  // One request, 42 bits
  typedef struct packed {
    alu_op_t          op;
    logic [ALU_W-1:0] a;
    // Only the low byte is used by byte ops
    logic [ALU_W-1:0] b;
    // Flags before the operation
    alu_flags_t       flags_in;
  } alu_req_t;

  // One result, 22 bits
  typedef struct packed {
    // Byte results come back zero-extended
    logic [ALU_W-1:0] value;
    alu_flags_t       flags;
  } alu_res_t;

endpackage

/* alu_math.sv */
// Combinational nibble-chained adder; DAA must arrive already mapped onto BADD or BSUB
`timescale 1ns/1ps

module alu_math (
  input  logic [alu_pkg::ALU_W-1:0] alua_in,
  input  logic [alu_pkg::ALU_W-1:0] alub_in,
  input  alu_pkg::alu_op_t          aluop_reg,
  input  logic                      carry_bit,
  input  logic                      carry_daa,
  input  logic                      daa_op,
  input  logic                      word_op,
  output logic [alu_pkg::ALU_W-1:0] adder_out,
  output logic                      adder_c,
  output logic                      adder_hc,
  output logic                      adder_ov
);

  logic                                                sub_op;
  logic                                                alu_cin;
  logic [alu_pkg::ALU_W-1:0]                           b_eff;
  // Per nibble, bit ALU_NW is the carry or borrow out
  logic [alu_pkg::ALU_NIB-1:0][alu_pkg::ALU_NW:0]      nib;

  // Subtract ops and which ops take the carry flag in
  always_comb begin
    sub_op  = 1'b0;
    alu_cin = 1'b0;
    case (aluop_reg)
      alu_pkg::AOP_SUB,
      alu_pkg::AOP_BSUB: sub_op = 1'b1;
      alu_pkg::AOP_SBC,
      alu_pkg::AOP_BSBC: begin
        sub_op  = 1'b1;
        alu_cin = carry_bit;
      end
      alu_pkg::AOP_ADC,
      alu_pkg::AOP_BADC: alu_cin = carry_bit;
      default: ;
    endcase
  end

  // ADS adds a signed byte offset to a word
  assign b_eff = (aluop_reg == alu_pkg::AOP_ADS) ?
                 {{alu_pkg::ALU_BW{alub_in[alu_pkg::ALU_BW-1]}}, alub_in[alu_pkg::ALU_BW-1:0]} :
                 alub_in;

  // Ripple through the nibbles, low to high
  always_comb begin
    logic cy;
    cy = alu_cin;
    for (int i = 0; i < alu_pkg::ALU_NIB; i++) begin
      if (sub_op) begin
        nib[i] = {1'b0, alua_in[i*alu_pkg::ALU_NW +: alu_pkg::ALU_NW]}
               - {1'b0, b_eff[i*alu_pkg::ALU_NW +: alu_pkg::ALU_NW]}
               - {{alu_pkg::ALU_NW{1'b0}}, cy};
      end else begin
        nib[i] = {1'b0, alua_in[i*alu_pkg::ALU_NW +: alu_pkg::ALU_NW]}
               + {1'b0, b_eff[i*alu_pkg::ALU_NW +: alu_pkg::ALU_NW]}
               + {{alu_pkg::ALU_NW{1'b0}}, cy};
      end
      cy = nib[i][alu_pkg::ALU_NW];
    end
  end

  always_comb begin
    for (int i = 0; i < alu_pkg::ALU_NIB; i++) begin
      adder_out[i*alu_pkg::ALU_NW +: alu_pkg::ALU_NW] = nib[i][alu_pkg::ALU_NW-1:0];
    end
  end

  // Carry out of bit 15 or bit 7, DAA overrides
  assign adder_c  = word_op ? nib[3][alu_pkg::ALU_NW] :
                    daa_op  ? carry_daa : nib[1][alu_pkg::ALU_NW];
  // Half carry out of bit 11 or bit 3
  assign adder_hc = word_op ? nib[2][alu_pkg::ALU_NW] : nib[0][alu_pkg::ALU_NW];

  // Signed overflow, operand signs against result sign
  always_comb begin
    case (aluop_reg)
      alu_pkg::AOP_ADD,
      alu_pkg::AOP_ADC:  adder_ov = (alua_in[15] == b_eff[15]) && (adder_out[15] != alua_in[15]);
      alu_pkg::AOP_SUB,
      alu_pkg::AOP_SBC:  adder_ov = (alua_in[15] != b_eff[15]) && (adder_out[15] != alua_in[15]);
      alu_pkg::AOP_BADD,
      alu_pkg::AOP_BADC: adder_ov = (alua_in[7] == b_eff[7]) && (adder_out[7] != alua_in[7]);
      alu_pkg::AOP_BSUB,
      alu_pkg::AOP_BSBC: adder_ov = (alua_in[7] != b_eff[7]) && (adder_out[7] != alua_in[7]);
      default:           adder_ov = 1'b0;
    endcase
  end

endmodule

/* alu_logic.sv */
// Byte AND/OR/XOR only; output is zero for every non-logic opcode
`timescale 1ns/1ps

module alu_logic (
  input  logic [alu_pkg::ALU_BW-1:0] a,
  input  logic [alu_pkg::ALU_BW-1:0] b,
  input  alu_pkg::alu_op_t           op,
  output logic [alu_pkg::ALU_BW-1:0] logic_out,
  output logic                       logic_par
);

  // Bitwise function select
  always_comb begin
    case (op)
      alu_pkg::AOP_AND: begin
        logic_out = a & b;
      end
      alu_pkg::AOP_OR: begin
        logic_out = a | b;
      end
      alu_pkg::AOP_XOR: begin
        logic_out = a ^ b;
      end
      default: begin
        // Not a logic op, keep the bus quiet
        logic_out = '0;
      end
    endcase
  end

  // Even parity, set for an even count of ones
  assign logic_par = ~^logic_out;

endmodule

/* alu_daa.sv */
// DAA correction per the Z80 table; assumes the accumulator is the low byte of operand a
`timescale 1ns/1ps

module alu_daa (
  input  logic [alu_pkg::ALU_BW-1:0] acc,
  input  alu_pkg::alu_flags_t        flags_in,
  output logic [alu_pkg::ALU_BW-1:0] daa_corr,
  output logic                       carry_daa
);

  logic lo_fix;
  logic hi_fix;

  // Low digit out of BCD range or a half carry came in
  assign lo_fix = (acc[alu_pkg::ALU_NW-1:0] > alu_pkg::DAA_LO_MAX) || flags_in.h;

  // Whole byte past 99 or a carry came in
  assign hi_fix = (acc > alu_pkg::DAA_HI_MAX) || flags_in.c;

  // Both corrections can apply at once, giving 66
  always_comb begin
    daa_corr = '0;
    if (lo_fix) begin
      daa_corr = daa_corr | alu_pkg::DAA_LO_CORR;
    end
    if (hi_fix) begin
      daa_corr = daa_corr | alu_pkg::DAA_HI_CORR;
    end
  end

  // Decimal carry out
  assign carry_daa = hi_fix;

endmodule

/* alu_flag_gen.sv */
// Result mux and flag forming; expects word_op, daa_op and log_op decoded by the caller
`timescale 1ns/1ps

module alu_flag_gen (
  input  alu_pkg::alu_op_t           op,
  input  logic                       word_op,
  input  logic                       daa_op,
  input  logic                       log_op,
  input  logic [alu_pkg::ALU_W-1:0]  adder_out,
  input  logic                       adder_c,
  input  logic                       adder_hc,
  input  logic                       adder_ov,
  input  logic [alu_pkg::ALU_BW-1:0] logic_out,
  input  logic                       logic_par,
  input  alu_pkg::alu_flags_t        flags_in,
  output alu_pkg::alu_res_t          res
);

  logic [alu_pkg::ALU_W-1:0] value;

  // Byte results are zero-extended
  always_comb begin
    if (log_op) begin
      value = {{(alu_pkg::ALU_W-alu_pkg::ALU_BW){1'b0}}, logic_out};
    end else if (word_op) begin
      value = adder_out;
    end else begin
      value = {{(alu_pkg::ALU_W-alu_pkg::ALU_BW){1'b0}}, adder_out[alu_pkg::ALU_BW-1:0]};
    end
  end

  always_comb begin
    res.value   = value;
    // Sign from the top bit of the result width
    res.flags.s = word_op ? value[alu_pkg::ALU_W-1] : value[alu_pkg::ALU_BW-1];
    res.flags.z = (value == '0);
    // Arithmetic defaults
    res.flags.h  = adder_hc;
    res.flags.pv = adder_ov;
    res.flags.c  = adder_c;
    res.flags.n  = 1'b0;
    if (log_op) begin
      // Z80 sets H only on AND
      res.flags.h  = (op == alu_pkg::AOP_AND);
      res.flags.pv = logic_par;
      res.flags.c  = 1'b0;
    end else if (daa_op) begin
      // Parity of the adjusted byte, N passes through
      res.flags.pv = ~^adder_out[alu_pkg::ALU_BW-1:0];
      res.flags.n  = flags_in.n;
    end else begin
      case (op)
        alu_pkg::AOP_SUB,
        alu_pkg::AOP_SBC,
        alu_pkg::AOP_BSUB,
        alu_pkg::AOP_BSBC: res.flags.n = 1'b1;
        alu_pkg::AOP_ADS:  res.flags.pv = 1'b0;
        default: ;
      endcase
    end
  end

endmodule

/* alu_top.sv */
// Registered ALU, fixed 2-edge latency, no back-pressure; one result per accepted req_vld
`timescale 1ns/1ps

module alu_top (
  input  logic              clkc,
  input  logic              rst,
  input  logic              req_vld,
  input  alu_pkg::alu_req_t req,
  output logic              res_vld,
  output alu_pkg::alu_res_t res
);

  alu_pkg::alu_req_t         req_q;
  logic                      req_vld_q;
  logic                      word_op;
  logic                      daa_op;
  logic                      log_op;
  alu_pkg::alu_op_t          math_op;
  logic [alu_pkg::ALU_W-1:0] math_b;
  logic [alu_pkg::ALU_BW-1:0] daa_corr;
  logic                      carry_daa;
  logic [alu_pkg::ALU_W-1:0] adder_out;
  logic                      adder_c;
  logic                      adder_hc;
  logic                      adder_ov;
  logic [alu_pkg::ALU_BW-1:0] logic_out;
  logic                      logic_par;
  alu_pkg::alu_res_t         res_next;

  // Input stage, payload loads only on a strobe
  always_ff @(posedge clkc) begin
    if (req_vld) begin
      req_q <= req;
    end
  end

  // Opcode classes, decoded once here
  assign word_op = req_q.op inside {alu_pkg::AOP_ADD, alu_pkg::AOP_ADC, alu_pkg::AOP_SUB,
                                    alu_pkg::AOP_SBC, alu_pkg::AOP_ADS};
  assign daa_op  = (req_q.op == alu_pkg::AOP_DAA);
  assign log_op  = req_q.op inside {alu_pkg::AOP_AND, alu_pkg::AOP_OR, alu_pkg::AOP_XOR};

  // DAA runs through the adder as a byte add or subtract of the correction
  assign math_op = !daa_op ? req_q.op :
                   req_q.flags_in.n ? alu_pkg::AOP_BSUB : alu_pkg::AOP_BADD;
  assign math_b  = daa_op ? {{(alu_pkg::ALU_W-alu_pkg::ALU_BW){1'b0}}, daa_corr} : req_q.b;

  alu_daa i_alu_daa (
    .acc       (req_q.a[alu_pkg::ALU_BW-1:0]),
    .flags_in  (req_q.flags_in),
    .daa_corr  (daa_corr),
    .carry_daa (carry_daa)
  );

  alu_math i_alu_math (
    .alua_in   (req_q.a),
    .alub_in   (math_b),
    .aluop_reg (math_op),
    .carry_bit (req_q.flags_in.c),
    .carry_daa (carry_daa),
    .daa_op    (daa_op),
    .word_op   (word_op),
    .adder_out (adder_out),
    .adder_c   (adder_c),
    .adder_hc  (adder_hc),
    .adder_ov  (adder_ov)
  );

  alu_logic i_alu_logic (
    .a         (req_q.a[alu_pkg::ALU_BW-1:0]),
    .b         (req_q.b[alu_pkg::ALU_BW-1:0]),
    .op        (req_q.op),
    .logic_out (logic_out),
    .logic_par (logic_par)
  );

  alu_flag_gen i_alu_flag_gen (
    .op        (req_q.op),
    .word_op   (word_op),
    .daa_op    (daa_op),
    .log_op    (log_op),
    .adder_out (adder_out),
    .adder_c   (adder_c),
    .adder_hc  (adder_hc),
    .adder_ov  (adder_ov),
    .logic_out (logic_out),
    .logic_par (logic_par),
    .flags_in  (req_q.flags_in),
    .res       (res_next)
  );

  // Valid pipe and output stage, result held between strobes
  always_ff @(posedge clkc) begin
    if (rst) begin
      req_vld_q <= 1'b0;
      res_vld   <= 1'b0;
      res       <= '0;
    end else begin
      req_vld_q <= req_vld;
      res_vld   <= req_vld_q;
      if (req_vld_q) begin
        res <= res_next;
      end
    end
  end

endmodule

/* alu_tb_ref.svh */
// Testbench reference model of the ALU; behavioral, includes the DAA table in line
`ifndef ALU_TB_REF_SVH
`define ALU_TB_REF_SVH

// Expected result of one request
function automatic alu_pkg::alu_res_t alu_ref(input alu_pkg::alu_req_t req);
  alu_pkg::alu_res_t r;
  logic [16:0] full;
  logic [12:0] half_w;
  logic [8:0]  full_b;
  logic [4:0]  half_b;
  logic [15:0] bx;
  logic [7:0]  corr;
  logic [7:0]  lg;
  logic        sub;
  logic        cin;
  logic        dc;
  logic        word;
  word = req.op inside {alu_pkg::AOP_ADD, alu_pkg::AOP_ADC, alu_pkg::AOP_SUB,
                        alu_pkg::AOP_SBC, alu_pkg::AOP_ADS};
  sub  = (req.op inside {alu_pkg::AOP_SUB, alu_pkg::AOP_SBC, alu_pkg::AOP_BSUB,
                         alu_pkg::AOP_BSBC}) ||
         ((req.op == alu_pkg::AOP_DAA) && req.flags_in.n);
  cin  = (req.op inside {alu_pkg::AOP_ADC, alu_pkg::AOP_SBC, alu_pkg::AOP_BADC,
                         alu_pkg::AOP_BSBC}) ? req.flags_in.c : 1'b0;
  // Decimal correction
  dc   = req.flags_in.c || (req.a[7:0] > 8'h99);
  corr = {dc ? 4'h6 : 4'h0, (req.flags_in.h || (req.a[3:0] > 4'h9)) ? 4'h6 : 4'h0};
  bx   = (req.op == alu_pkg::AOP_ADS) ? {{8{req.b[7]}}, req.b[7:0]} :
         (req.op == alu_pkg::AOP_DAA) ? {8'h00, corr} : req.b;
  if (sub) begin
    full   = {1'b0, req.a} - {1'b0, bx} - {16'h0, cin};
    half_w = {1'b0, req.a[11:0]} - {1'b0, bx[11:0]} - {12'h0, cin};
    full_b = {1'b0, req.a[7:0]} - {1'b0, bx[7:0]} - {8'h0, cin};
    half_b = {1'b0, req.a[3:0]} - {1'b0, bx[3:0]} - {4'h0, cin};
  end else begin
    full   = {1'b0, req.a} + {1'b0, bx} + {16'h0, cin};
    half_w = {1'b0, req.a[11:0]} + {1'b0, bx[11:0]} + {12'h0, cin};
    full_b = {1'b0, req.a[7:0]} + {1'b0, bx[7:0]} + {8'h0, cin};
    half_b = {1'b0, req.a[3:0]} + {1'b0, bx[3:0]} + {4'h0, cin};
  end
  r.value    = word ? full[15:0] : {8'h00, full_b[7:0]};
  r.flags.s  = word ? r.value[15] : r.value[7];
  r.flags.z  = (r.value == 16'h0);
  r.flags.h  = word ? half_w[12] : half_b[4];
  r.flags.c  = word ? full[16] : full_b[8];
  r.flags.n  = sub;
  // Overflow, signs of a and b against the result
  r.flags.pv = word ? (((req.a[15] ~^ bx[15]) ^ sub) && (full[15] != req.a[15])) :
                      (((req.a[7] ~^ bx[7]) ^ sub) && (full_b[7] != req.a[7]));
  case (req.op)
    alu_pkg::AOP_ADS: r.flags.pv = 1'b0;
    alu_pkg::AOP_AND,
    alu_pkg::AOP_OR,
    alu_pkg::AOP_XOR: begin
      lg = (req.op == alu_pkg::AOP_AND) ? (req.a[7:0] & req.b[7:0]) :
           (req.op == alu_pkg::AOP_OR)  ? (req.a[7:0] | req.b[7:0]) :
                                          (req.a[7:0] ^ req.b[7:0]);
      r.value = {8'h00, lg};
      r.flags = '{s: lg[7], z: (lg == 8'h00), h: (req.op == alu_pkg::AOP_AND),
                  pv: ~^lg, n: 1'b0, c: 1'b0};
    end
    alu_pkg::AOP_DAA: begin
      r.flags.pv = ~^full_b[7:0];
      r.flags.n  = req.flags_in.n;
      r.flags.c  = dc;
    end
    default: ;
  endcase
  return r;
endfunction

`endif

/* alu_tb.sv */
// Self-checking ALU testbench; stops at the first mismatch, drain wait limited to 20 cycles
`timescale 1ns/1ps

module alu_tb;

  logic              clkc;
  logic              rst;
  logic              req_vld;
  alu_pkg::alu_req_t req;
  logic              res_vld;
  alu_pkg::alu_res_t res;

  // Scoreboard of expected results and the edge count each is due at
  alu_pkg::alu_res_t exp_q[$];
  int                due_q[$];
  int                edge_cnt = 0;
  logic [31:0]       rng = 32'h932fe080;

  `include "alu_tb_ref.svh"

  alu_top i_alu_top (
    .clkc    (clkc),
    .rst     (rst),
    .req_vld (req_vld),
    .req     (req),
    .res_vld (res_vld),
    .res     (res)
  );

  // 100 ns clock
  initial begin
    clkc = 1'b0;
    forever #50 clkc = ~clkc;
  end

  always @(posedge clkc) edge_cnt <= edge_cnt + 1;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Opcode from a contiguous group of the enum
  function automatic alu_pkg::alu_op_t pick_op(input int first, input int count,
                                               input logic [31:0] r);
    return alu_pkg::alu_op_t'(4'(first + int'(r % count)));
  endfunction

  function automatic alu_pkg::alu_req_t make_req(input alu_pkg::alu_op_t op,
                                                 input logic [15:0] a, input logic [15:0] b,
                                                 input alu_pkg::alu_flags_t f);
    alu_pkg::alu_req_t r;
    r.op       = op;
    r.a        = a;
    r.b        = b;
    r.flags_in = f;
    return r;
  endfunction

  function automatic logic [7:0] to_bcd(input int v);
    return {4'(v / 10), 4'(v % 10)};
  endfunction

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
      $display("Errors found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // One request is sampled at the next edge
  task automatic drive(input alu_pkg::alu_req_t r);
    @(posedge clkc);
    #10;
    req_vld = 1'b1;
    req     = r;
    exp_q.push_back(alu_ref(r));
    due_q.push_back(edge_cnt + 2);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clkc);
      #10;
      req_vld = 1'b0;
      // Junk on the bus must be ignored
      req.a   = 16'(rand32() >> 16);
    end
  endtask

  // BCD add or subtract followed by DAA on the flags it left behind
  task automatic bcd_case(input bit do_sub);
    logic [31:0]       r;
    int                xd;
    int                yd;
    int                dec;
    alu_pkg::alu_req_t add_req;
    alu_pkg::alu_req_t daa_req;
    alu_pkg::alu_res_t add_res;
    alu_pkg::alu_res_t daa_res;
    r       = rand32();
    xd      = int'(r[7:0]) % 100;
    yd      = int'(r[15:8]) % 100;
    add_req = make_req(do_sub ? alu_pkg::AOP_BSUB : alu_pkg::AOP_BADD,
                       {8'h00, to_bcd(xd)}, {8'h00, to_bcd(yd)}, '0);
    add_res = alu_ref(add_req);
    drive(add_req);
    daa_req = make_req(alu_pkg::AOP_DAA, add_res.value, r[31:16], add_res.flags);
    daa_res = alu_ref(daa_req);
    // Decimal view of the same sum
    dec     = do_sub ? xd - yd : xd + yd;
    compare("DAA decimal value", 32'(daa_res.value), 32'(to_bcd((dec + 100) % 100)));
    compare("DAA decimal carry", 32'(daa_res.flags.c), 32'((dec > 99) || (dec < 0)));
    drive(daa_req);
  endtask

  // Compare at the falling edge where outputs have settled
  always @(negedge clkc) begin
    alu_pkg::alu_res_t exp_r;
    logic              exp_vld;
    if (edge_cnt > 0) begin
      if (res_vld === 1'b1 && exp_q.size() == 0) begin
        $display("Error at %0t ns: res_vld high with no request outstanding", $time);
        $display("Errors found");
        $fatal(1, "stopped on unexpected result");
      end
      exp_vld = (due_q.size() > 0) && (due_q[0] == edge_cnt);
      compare("res_vld", 32'(res_vld), 32'(exp_vld));
      if (exp_vld) begin
        exp_r = exp_q.pop_front();
        void'(due_q.pop_front());
        compare("value", 32'(res.value), 32'(exp_r.value));
        compare("flags", 32'(res.flags), 32'(exp_r.flags));
      end
    end
  end

  initial begin
    logic [31:0] r1;
    logic [31:0] r2;
    int          wait_cnt;
    rst     = 1'b1;
    req_vld = 1'b0;
    req     = '0;
    repeat (8) @(posedge clkc);
    #10;
    rst = 1'b0;
    compare("res after reset", 32'(res), 32'h0);
    idle(2);
    // Word ops with random carry-in and ADS offsets of both signs
    repeat (60) begin
      r1 = rand32();
      r2 = rand32();
      drive(make_req(pick_op(int'(alu_pkg::AOP_ADD), 5, r1), r1[31:16], r2[15:0],
                     alu_pkg::alu_flags_t'(r2[21:16])));
    end
    idle(3);
    // Byte overflow corners with junk in the upper byte of a
    drive(make_req(alu_pkg::AOP_BADD, 16'hA57F, 16'h0001, '0));
    drive(make_req(alu_pkg::AOP_BSUB, 16'h5A80, 16'h0001, '0));
    drive(make_req(alu_pkg::AOP_BADC, 16'hFF7F, 16'h3C00, 6'h01));
    drive(make_req(alu_pkg::AOP_BSBC, 16'h0180, 16'h0000, 6'h01));
    repeat (40) begin
      r1 = rand32();
      r2 = rand32();
      drive(make_req(pick_op(int'(alu_pkg::AOP_BADD), 4, r1), r1[31:16], r2[15:0],
                     alu_pkg::alu_flags_t'(r2[21:16])));
    end
    idle(2);
    // Logic ops set h on AND only and parity in pv
    repeat (30) begin
      r1 = rand32();
      drive(make_req(pick_op(int'(alu_pkg::AOP_AND), 3, r1), r1[31:16], r1[15:0],
                     alu_pkg::alu_flags_t'(r1[5:0])));
    end
    idle(4);
    repeat (20) bcd_case(1'b0);
    repeat (20) bcd_case(1'b1);
    // Any op with idle gaps
    repeat (80) begin
      r1 = rand32();
      r2 = rand32();
      if (r1[31]) begin
        drive(make_req(pick_op(int'(alu_pkg::AOP_ADD), 13, r1), r1[15:0], r2[15:0],
                       alu_pkg::alu_flags_t'(r2[21:16])));
      end else begin
        idle(1);
      end
    end
    idle(1);
    wait_cnt = 0;
    while (exp_q.size() != 0 && wait_cnt < 20) begin
      @(posedge clkc);
      wait_cnt++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout: %0d results never arrived", exp_q.size());
      $display("Errors found");
      $fatal(1, "drain timeout");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

/* all.f */
+incdir+.
alu_pkg.sv
alu_math.sv
alu_logic.sv
alu_daa.sv
alu_flag_gen.sv
alu_top.sv
alu_tb.sv

/* Makefile */
# Verilator build and run of the ALU testbench

VERILATOR ?= verilator
TOP       ?= alu_tb
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= No errors

SRCS := $(shell grep -v '^+' $(FLIST)) alu_tb_ref.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Pass only when the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
